/* verilog.f */
verilog/lookup_pkg.sv
verilog/beat_fifo.sv
verilog/header_match.sv
verilog/window_timer.sv
verilog/ctrl_inject_fsm.sv
verilog/nic_output_lookup.sv
sim/tb_nic_output_lookup.sv

/* Bender.yml */
package:
  name: nic_output_lookup

sources:
  - verilog/lookup_pkg.sv
  - verilog/beat_fifo.sv
  - verilog/header_match.sv
  - verilog/window_timer.sv
  - verilog/ctrl_inject_fsm.sv
  - verilog/nic_output_lookup.sv
  - target: simulation
    files:
      - sim/tb_nic_output_lookup.sv

/* sim/tb_nic_output_lookup.sv */
// one packet in flight at a time with idle gaps of six or more cycles; fixed seed, table-driven
`timescale 1ns/1ps
`default_nettype none

module tb_nic_output_lookup;

  import lookup_pkg::*;

  // stimulus row with packet shape, setup and expected injection
  typedef struct packed {
    logic [mac_bits-1:0]    dst_mac;
    logic [3:0]             beats;
    logic [7:0]             port;
    logic                   stall;
    logic                   rst_first;
    logic [window_bits-1:0] limit;
    logic [15:0]            min_age;
    logic                   exp_inject;
  } pkt_row_t;

  localparam logic [mac_bits-1:0] own_mac   = 48'h0a1b2c3d4e5f;
  localparam logic [mac_bits-1:0] other_mac = 48'h665544332211;

  logic           axi_aclk;
  logic           axi_resetn;
  lookup_cfg_t    cfg;
  axis_beat_t     s_beat;
  logic           s_valid;
  logic           s_ready;
  axis_beat_t     m_beat;
  logic           m_valid;
  logic           m_ready;
  lookup_status_t status;

  pkt_row_t   rows[$];
  axis_beat_t ref_q[$];
  integer     seed = 52116;
  int         error_count = 0;
  int         check_count = 0;
  int         cycle_count = 0;
  int         cycle_limit = 2000;
  int         last_rst_cycle = 0;
  bit         pkt_sent;
  bit         saw_backpressure = 0;

  nic_output_lookup dut_i (
    .axi_aclk   (axi_aclk),
    .axi_resetn (axi_resetn),
    .cfg        (cfg),
    .s_beat     (s_beat),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_beat     (m_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .status     (status)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #2 axi_aclk = ~axi_aclk;
  end

  // run limit set once the table is loaded
  always @(posedge axi_aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("ERROR: timeout after %0d cycles, output never drained", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [data_bits-1:0] got,
                             input logic [data_bits-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [mac_bits-1:0] mac, input logic [3:0] beats,
                         input logic [7:0] port, input logic stall, input logic rst_first,
                         input logic [window_bits-1:0] limit, input logic [15:0] min_age,
                         input logic exp_inject);
    rows.push_back('{mac, beats, port, stall, rst_first, limit, min_age, exp_inject});
  endtask

  // inputs change 1 ns after the edge
  task automatic step();
    @(posedge axi_aclk);
    #1;
  endtask

  task automatic send_packet(input pkt_row_t row);
    axis_beat_t           beat;
    logic [data_bits-1:0] data;
    bit                   taken;
    for (int b = 0; b < row.beats; b++) begin
      for (int w = 0; w < data_bits / 32; w++)
        data[w*32 +: 32] = $random(seed);
      // destination MAC sits in the low bytes of the first beat
      if (b == 0)
        data[mac_bits-1:0] = row.dst_mac;
      beat.tdata = data;
      beat.tstrb = '1;
      if (b == row.beats - 1)
        beat.tstrb = $random(seed) | 1;
      beat.tuser = '0;
      beat.tuser[dst_port_pos +: 8] = row.port;
      beat.tlast = (b == row.beats - 1);
      s_beat  = beat;
      s_valid = 1'b1;
      taken   = 1'b0;
      // s_ready is stable by the falling edge
      while (!taken) begin
        @(negedge axi_aclk);
        taken = s_ready;
        step();
      end
      ref_q.push_back(beat);
    end
    s_valid = 1'b0;
    // control packet of two beats with full strobes, port 4 and tlast on the second
    if (row.exp_inject) begin
      beat.tdata = ctrl_beat0_data;
      beat.tstrb = '1;
      beat.tuser = '0;
      beat.tuser[dst_port_pos +: 8] = 8'h04;
      beat.tlast = 1'b0;
      ref_q.push_back(beat);
      beat.tdata = ctrl_beat1_data;
      beat.tlast = 1'b1;
      ref_q.push_back(beat);
    end
    pkt_sent = 1'b1;
  endtask

  // stalled rows open with 8 cycles of back-pressure followed by random runs
  task automatic drive_ready(input logic stall);
    int run;
    int r;
    run = stall ? 8 : 0;
    while (!(pkt_sent && ref_q.size() == 0)) begin
      if (run > 0) begin
        m_ready = 1'b0;
        run--;
      end else if (stall) begin
        r = $random(seed) & 7;
        m_ready = (r >= 2);
        if (r < 2)
          run = $random(seed) & 7;
      end else begin
        m_ready = 1'b1;
      end
      step();
    end
    m_ready = 1'b1;
  endtask

  // monitor samples both handshakes at the falling edge
  always @(negedge axi_aclk) begin : monitor
    axis_beat_t    exp;
    inject_state_t st;
    if (axi_resetn && s_valid && !s_ready)
      saw_backpressure = 1'b1;
    if (axi_resetn && m_valid && m_ready) begin
      if (ref_q.size() == 0) begin
        st = dut_i.u_fsm.state;
        error_count++;
        $display("ERROR at %0t: unexpected output beat, FSM in %s", $time, st.name());
      end else begin
        exp = ref_q.pop_front();
        check_value("m_beat.tdata", m_beat.tdata, exp.tdata);
        check_value("m_beat.tstrb", m_beat.tstrb, exp.tstrb);
        check_value("m_beat.tuser", m_beat.tuser, exp.tuser);
        check_value("m_beat.tlast", m_beat.tlast, exp.tlast);
      end
    end
  end

  initial begin
    pkt_row_t row;
    int       total_beats;
    axi_resetn       = 1'b0;
    cfg.match_mac    = own_mac;
    cfg.window_limit = '1;
    cfg.rst_cntrs    = 1'b0;
    s_beat           = '0;
    s_valid          = 1'b0;
    m_ready          = 1'b1;
    // mac, beats, port, stall, rst first, window limit, min age, inject
    add_row(other_mac, 3, 8'h01, 0, 0, '1, 0, 0);
    add_row(own_mac,   1, 8'h02, 0, 0, '1, 0, 1);
    add_row(own_mac,   4, 8'h03, 0, 0, '1, 0, 1);
    add_row(other_mac, 5, 8'h01, 1, 0, '1, 0, 0);
    add_row(own_mac,   6, 8'h02, 1, 0, '1, 0, 1);
    add_row(other_mac, 2, 8'h05, 1, 0, '1, 0, 0);
    // window closed once an epoch has passed
    add_row(own_mac,   3, 8'h01, 0, 0, 0, 300, 0);
    add_row(own_mac,   2, 8'h02, 0, 1, 0, 0, 1);
    add_row(own_mac,   4, 8'h03, 1, 1, 0, 0, 1);
    add_row(other_mac, 3, 8'h06, 0, 0, 0, 0, 0);
    add_row(own_mac,   2, 8'h02, 0, 0, 0, 300, 0);
    total_beats = 0;
    foreach (rows[i])
      total_beats += rows[i].beats + (rows[i].exp_inject ? 2 : 0);
    cycle_limit = 40 * total_beats + 2000;

    repeat (5) @(posedge axi_aclk);
    #1;
    // state while reset still holds
    check_value("m_valid", m_valid, 0);
    check_value("status.gate_open", status.gate_open, 0);
    check_value("status.mac_hit", status.mac_hit, 0);
    axi_resetn = 1'b1;
    last_rst_cycle = cycle_count;
    repeat (10) step();

    foreach (rows[i]) begin
      row = rows[i];
      cfg.window_limit = row.limit;
      if (row.rst_first) begin
        cfg.rst_cntrs = 1'b1;
        step();
        cfg.rst_cntrs = 1'b0;
        last_rst_cycle = cycle_count;
        step();
        check_value("status.epoch", status.epoch, 0);
        // epoch zero lies inside any window
        check_value("status.gate_open", status.gate_open, 1);
      end
      while (cycle_count - last_rst_cycle < row.min_age)
        step();
      pkt_sent = 1'b0;
      fork
        send_packet(row);
        drive_ready(row.stall);
      join
      repeat (6) step();
      // hit flag of the packet that just left
      check_value("status.mac_hit", status.mac_hit, row.dst_mac == own_mac);
      // widest window always open, zero window shut once an epoch has passed
      if (row.limit == '1)
        check_value("status.gate_open", status.gate_open, 1);
      else if (row.min_age > 256)
        check_value("status.gate_open", status.gate_open, 0);
    end

    repeat (20) step();
    if (!saw_backpressure) begin
      error_count++;
      $display("ERROR: s_ready never dropped under output stalls");
    end
    if (ref_q.size() != 0) begin
      error_count++;
      $display("ERROR: %0d expected beats never came out", ref_q.size());
    end
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/nic_output_lookup.sv */
// top level; input beats offered while s_ready is low are not taken, config is sampled live
`timescale 1ns/1ps
`default_nettype none

module nic_output_lookup (
  input  wire                         axi_aclk,
  input  wire                         axi_resetn,
  input  lookup_pkg::lookup_cfg_t     cfg,
  input  lookup_pkg::axis_beat_t      s_beat,
  input  wire                         s_valid,
  output logic                        s_ready,
  output lookup_pkg::axis_beat_t      m_beat,
  output logic                        m_valid,
  input  wire                         m_ready,
  output lookup_pkg::lookup_status_t  status
);

  import lookup_pkg::*;

  axis_beat_t fifo_beat;
  logic       fifo_empty;
  logic       fifo_nearly_full;
  logic       fifo_rd;
  logic       in_fire;

  logic                   mac_hit;
  logic                   gate_open;
  logic [window_bits-1:0] epoch;

  // input handshake
  assign s_ready = !fifo_nearly_full;
  assign in_fire = s_valid && s_ready;

  beat_fifo u_fifo (
    .axi_aclk    (axi_aclk),
    .axi_resetn  (axi_resetn),
    .wr_beat     (s_beat),
    .wr_en       (in_fire),
    .rd_en       (fifo_rd),
    .rd_beat     (fifo_beat),
    .empty       (fifo_empty),
    .nearly_full (fifo_nearly_full)
  );

  // watches accepted input, not the fifo output
  header_match u_match (
    .axi_aclk   (axi_aclk),
    .axi_resetn (axi_resetn),
    .in_beat    (s_beat),
    .in_fire    (in_fire),
    .match_mac  (cfg.match_mac),
    .mac_hit    (mac_hit)
  );

  window_timer u_timer (
    .axi_aclk     (axi_aclk),
    .axi_resetn   (axi_resetn),
    .rst_cntrs    (cfg.rst_cntrs),
    .window_limit (cfg.window_limit),
    .gate_open    (gate_open),
    .epoch        (epoch)
  );

  ctrl_inject_fsm u_fsm (
    .axi_aclk   (axi_aclk),
    .axi_resetn (axi_resetn),
    .fifo_beat  (fifo_beat),
    .fifo_empty (fifo_empty),
    .fifo_rd    (fifo_rd),
    .mac_hit    (mac_hit),
    .gate_open  (gate_open),
    .m_beat     (m_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready)
  );

  // read-only view
  assign status.gate_open = gate_open;
  assign status.mac_hit   = mac_hit;
  assign status.epoch     = epoch;

endmodule

`default_nettype wire

/* verilog/ctrl_inject_fsm.sv */
// control packet only after a whole outgoing packet; mac_hit must already hold that packet's result
`timescale 1ns/1ps
`default_nettype none

module ctrl_inject_fsm (
  input  wire                     axi_aclk,
  input  wire                     axi_resetn,
  input  lookup_pkg::axis_beat_t  fifo_beat,
  input  wire                     fifo_empty,
  output logic                    fifo_rd,
  input  wire                     mac_hit,
  input  wire                     gate_open,
  output lookup_pkg::axis_beat_t  m_beat,
  output logic                    m_valid,
  input  wire                     m_ready
);

  import lookup_pkg::*;

  inject_state_t state;
  inject_state_t state_next;

  // injected tuser carries only the port field
  logic [user_bits-1:0] ctrl_user;

  always_comb begin
    ctrl_user = '0;
    ctrl_user[dst_port_pos +: $bits(ctrl_dst_port)] = ctrl_dst_port;
  end

  // output mux and next state
  always_comb begin
    state_next = state;
    m_beat     = fifo_beat;
    m_valid    = 1'b0;
    fifo_rd    = 1'b0;

    case (state)
      st_pass_head: begin
        m_valid = !fifo_empty;
        fifo_rd = m_ready && !fifo_empty;
        // single-beat packets go straight to the check
        if (m_valid && m_ready) begin
          state_next = fifo_beat.tlast ? st_check : st_pass_data;
        end
      end

      st_pass_data: begin
        m_valid = !fifo_empty;
        fifo_rd = m_ready && !fifo_empty;
        if (m_valid && m_ready && fifo_beat.tlast) begin
          state_next = st_check;
        end
      end

      // one idle cycle with nothing offered
      st_check: begin
        if (mac_hit && gate_open) begin
          state_next = st_ctrl_first;
        end else begin
          state_next = st_pass_head;
        end
      end

      // fifo held while the control beats go out
      st_ctrl_first: begin
        m_valid      = 1'b1;
        m_beat.tdata = ctrl_beat0_data;
        m_beat.tstrb = '1;
        m_beat.tuser = ctrl_user;
        m_beat.tlast = 1'b0;
        if (m_ready) begin
          state_next = st_ctrl_second;
        end
      end

      st_ctrl_second: begin
        m_valid      = 1'b1;
        m_beat.tdata = ctrl_beat1_data;
        m_beat.tstrb = '1;
        m_beat.tuser = ctrl_user;
        m_beat.tlast = 1'b1;
        if (m_ready) begin
          state_next = st_pass_head;
        end
      end

      default: begin
        state_next = st_pass_head;
      end
    endcase
  end

  // state register starting in pass-through
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      state <= st_pass_head;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/window_timer.sv */
// epoch advances every 2**prescale_bits cycles and wraps silently; gate open while epoch <= limit
`timescale 1ns/1ps
`default_nettype none

module window_timer (
  input  wire                                 axi_aclk,
  input  wire                                 axi_resetn,
  input  wire                                 rst_cntrs,
  input  wire  [lookup_pkg::window_bits-1:0]  window_limit,
  output logic                                gate_open,
  output logic [lookup_pkg::window_bits-1:0]  epoch
);

  import lookup_pkg::*;

  // free-running prescaler
  logic [prescale_bits-1:0] stamp;

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      stamp <= '0;
    end else if (rst_cntrs) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + 1'b1;
    end
  end

  // epoch steps on prescaler wrap
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      epoch <= '0;
    end else if (rst_cntrs) begin
      epoch <= '0;
    end else if (stamp == '1) begin
      epoch <= epoch + 1'b1;
    end
  end

  // registered window compare
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      gate_open <= 1'b0;
    end else begin
      gate_open <= (epoch <= window_limit);
    end
  end

endmodule

`default_nettype wire

/* verilog/header_match.sv */
// destination MAC taken from tdata[47:0] of each first beat; hit result lags the beat by two cycles
`timescale 1ns/1ps
`default_nettype none

module header_match (
  input  wire                                axi_aclk,
  input  wire                                axi_resetn,
  input  lookup_pkg::axis_beat_t             in_beat,
  input  wire                                in_fire,
  input  wire [lookup_pkg::mac_bits-1:0]     match_mac,
  output logic                               mac_hit
);

  import lookup_pkg::*;

  // high when the next accepted beat opens a packet
  logic in_sop;

  logic [mac_bits-1:0] dst_mac;
  logic                cap_vld;

  // packet boundary tracking
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      in_sop <= 1'b1;
    end else if (in_fire) begin
      in_sop <= in_beat.tlast;
    end
  end

  // latch the destination address of a first beat
  always_ff @(posedge axi_aclk) begin
    if (in_fire && in_sop) begin
      dst_mac <= in_beat.tdata[mac_bits-1:0];
    end
  end

  // strobe marks a fresh capture
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      cap_vld <= 1'b0;
    end else begin
      cap_vld <= in_fire && in_sop;
    end
  end

  // compare once per packet, then hold
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      mac_hit <= 1'b0;
    end else if (cap_vld) begin
      mac_hit <= (dst_mac == match_mac);
    end
  end

endmodule

`default_nettype wire

/* verilog/beat_fifo.sv */
// four-entry fall-through FIFO; writes into a full buffer and reads from an empty one are dropped
`timescale 1ns/1ps
`default_nettype none

module beat_fifo (
  input  wire                     axi_aclk,
  input  wire                     axi_resetn,
  input  lookup_pkg::axis_beat_t  wr_beat,
  input  wire                     wr_en,
  input  wire                     rd_en,
  output lookup_pkg::axis_beat_t  rd_beat,
  output logic                    empty,
  output logic                    nearly_full
);

  import lookup_pkg::*;

  // beat storage
  axis_beat_t mem [fifo_depth];

  logic [fifo_ptr_bits-1:0] wr_ptr;
  logic [fifo_ptr_bits-1:0] rd_ptr;
  logic [fifo_ptr_bits:0]   count;

  logic do_wr;
  logic do_rd;

  // guard against overflow and underflow
  assign do_wr = wr_en && (count != fifo_depth[fifo_ptr_bits:0]);
  assign do_rd = rd_en && !empty;

  always_ff @(posedge axi_aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // pointers and fill level
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry shows on the output without a read
  assign rd_beat = mem[rd_ptr];
  assign empty = (count == '0);

  // one slot of slack for a beat already in flight
  assign nearly_full = (count >= fifo_depth[fifo_ptr_bits:0] - 1'b1);

endmodule

`default_nettype wire

/* verilog/lookup_pkg.sv */
// shared widths, beat/config/status structs and control-packet constants; widths are fixed
`default_nettype none

package lookup_pkg;

  // stream geometry
  localparam int data_bits = 256;
  localparam int strb_bits = data_bits / 8;
  localparam int user_bits = 128;

  // destination port field in tuser
  localparam int dst_port_pos = 24;
  localparam logic [7:0] ctrl_dst_port = 8'h04;

  // window timing
  localparam int prescale_bits = 8;
  localparam int window_bits = 32;

  localparam int mac_bits = 48;

  // four-entry input buffer
  localparam int fifo_ptr_bits = 2;
  localparam int fifo_depth = 1 << fifo_ptr_bits;

  typedef struct packed {
    logic [data_bits-1:0] tdata;
    logic [strb_bits-1:0] tstrb;
    logic [user_bits-1:0] tuser;
    logic                 tlast;
  } axis_beat_t;

  typedef struct packed {
    logic [mac_bits-1:0]    match_mac;
    logic [window_bits-1:0] window_limit;
    logic                   rst_cntrs;
  } lookup_cfg_t;

  typedef struct packed {
    logic                   gate_open;
    logic                   mac_hit;
    logic [window_bits-1:0] epoch;
  } lookup_status_t;

  // header constants of the injected packet
  localparam logic [31:0] ctrl_dst_ip   = 32'h6501A8C0;
  localparam logic [31:0] ctrl_src_ip   = 32'h6401A8C0;
  localparam logic [15:0] ctrl_ip_csum  = 16'h0000;
  localparam logic [7:0]  ctrl_ip_proto = 8'h00;
  localparam logic [7:0]  ctrl_ip_ttl   = 8'h40;
  localparam logic [7:0]  ctrl_ip_tos   = 8'h00;
  localparam logic [47:0] ctrl_src_mac  = 48'h112233445566;
  localparam logic [47:0] ctrl_dst_mac  = 48'h223344556677;

  // beat 0 holds the mac header and the ip header up to the low half of the destination ip
  localparam logic [data_bits-1:0] ctrl_beat0_data = {
    ctrl_dst_ip[15:0], ctrl_src_ip, ctrl_ip_csum, ctrl_ip_proto, ctrl_ip_ttl,
    48'h0, ctrl_ip_tos, 8'h45, 16'h0c88, ctrl_src_mac, ctrl_dst_mac
  };

  // beat 1 carries the marker pattern above the high half of the destination ip
  localparam logic [data_bits-1:0] ctrl_beat1_data = {240'hdeadbeefbabe, ctrl_dst_ip[31:16]};

  typedef enum logic [2:0] {
    st_pass_head,
    st_pass_data,
    st_check,
    st_ctrl_first,
    st_ctrl_second
  } inject_state_t;

endpackage

`default_nettype wire
